/* verilog.f */
verilog/parking_pkg.sv
verilog/parking_fee_meter.sv
verilog/order_queue.sv
verilog/slot_allocator.sv
verilog/elevator_controller.sv
verilog/parking_tower_top.sv
testbench/parking_checker.sv
testbench/parking_asserts.sv
testbench/tb_parking_tower.sv

/* Bender.yml */
package:
  name: parking_tower

sources:
  - files:
      - verilog/parking_pkg.sv
      - verilog/parking_fee_meter.sv
      - verilog/order_queue.sv
      - verilog/slot_allocator.sv
      - verilog/elevator_controller.sv
      - verilog/parking_tower_top.sv
  - target: test
    files:
      - testbench/parking_checker.sv
      - testbench/parking_asserts.sv
      - testbench/tb_parking_tower.sv

/* testbench/tb_parking_tower.sv */
//--------------------
// Orders go through the four-phase handshake. Burst entries skip the idle gap
//--------------------
`timescale 1ns/1ps

module tb_parking_tower;
	import parking_pkg::*;

	localparam int NUM_FLOORS = 7;
	localparam int QUEUE_DEPTH = 8;
	localparam int CLOCK_PERIOD = 40;
	// Full round trip to the top floor plus handshake and idle gap
	localparam int WORST_CYCLES = 2 * NUM_FLOORS + 12;

	typedef struct packed {
		order_kind_t kind;
		logic [PLATE_W-1:0] plate;
		status_t status;
		logic burst;
	} stim_t;

	logic clock;
	logic reset;
	logic order_req;
	order_t order;
	logic order_ack;
	logic done_valid;
	result_t result;
	logic [3:0] free_sedan;
	logic [3:0] free_suv;
	logic [FLOOR_W-1:0] current_floor;
	int error_count;
	int test_count;
	int assert_count;
	stim_t stim_table [$];

	parking_tower_top #(.NUM_FLOORS(NUM_FLOORS), .QUEUE_DEPTH(QUEUE_DEPTH)) u_dut (
		.clock, .reset, .order_req, .order, .order_ack,
		.done_valid, .result, .free_sedan, .free_suv, .current_floor
	);

	parking_checker #(.NUM_FLOORS(NUM_FLOORS)) u_checker (
		.clock, .reset, .order, .order_ack, .done_valid, .result,
		.free_sedan, .free_suv, .current_floor, .error_count, .test_count
	);

	assign assert_count = u_dut.u_queue.u_queue_asserts.failures +
		u_dut.u_elevator.u_elevator_asserts.failures;

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	// Watchdog sized from the table length
	initial begin
		@(negedge reset);
		#(stim_table.size() * WORST_CYCLES * CLOCK_PERIOD);
		$display("Timeout: only %0d tests finished", test_count);
		$display("Test failures found");
		$finish;
	end

	task automatic add_entry(input order_kind_t kind, input logic [PLATE_W-1:0] plate,
			input status_t status, input logic burst);
		stim_table.push_back({kind, plate, status, burst});
	endtask

	// Four-phase handshake, order held until the next call
	task automatic send_order(input order_t next);
		@(negedge clock);
		order = next;
		order_req = 1'b1;
		do @(negedge clock); while (!order_ack);
		order_req = 1'b0;
		do @(negedge clock); while (order_ack);
	endtask

	initial begin
		stim_t entry;
		int unsigned seed;
		seed = $urandom(32'hd9f6);
		reset = 1'b1;
		order_req = 1'b0;
		order = '0;
		// Normal cars come back soon so their fees stay below saturation
		add_entry(PARK, 16'h1002, OK, 1'b0);
		add_entry(RETRIEVE, 16'h1002, OK, 1'b0);
		add_entry(PARK, 16'h2001, OK, 1'b0);
		add_entry(PARK, 16'h9011, OK, 1'b0);
		add_entry(PARK, 16'h9010, OK, 1'b0);
		add_entry(PARK, 16'h8021, OK, 1'b0);
		add_entry(RETRIEVE, 16'h2001, OK, 1'b0);
		add_entry(RETRIEVE, 16'h9011, OK, 1'b0);
		add_entry(RETRIEVE, 16'h8021, OK, 1'b0);
		add_entry(RETRIEVE, 16'h1234, NOT_FOUND, 1'b0);
		add_entry(RETRIEVE, 16'h9010, OK, 1'b0);
		// Burst longer than the queue. Fills every sedan slot
		add_entry(PARK, 16'h1102, OK, 1'b1);
		add_entry(PARK, 16'h1104, OK, 1'b1);
		add_entry(PARK, 16'h1106, OK, 1'b1);
		add_entry(PARK, 16'h1108, OK, 1'b1);
		add_entry(PARK, 16'h110a, OK, 1'b1);
		add_entry(PARK, 16'h110c, FULL, 1'b1);
		add_entry(PARK, 16'h9102, OK, 1'b1);
		add_entry(PARK, 16'h9104, FULL, 1'b1);
		add_entry(RETRIEVE, 16'h1102, OK, 1'b1);
		add_entry(RETRIEVE, 16'h1104, OK, 1'b1);
		add_entry(RETRIEVE, 16'h1106, OK, 1'b1);
		add_entry(RETRIEVE, 16'h1108, OK, 1'b1);
		add_entry(RETRIEVE, 16'h110a, OK, 1'b1);
		add_entry(RETRIEVE, 16'h9102, OK, 1'b1);
		repeat (3) @(negedge clock);
		reset = 1'b0;
		foreach (stim_table[i]) begin
			entry = stim_table[i];
			if (!entry.burst)
				repeat ($urandom % 4) @(negedge clock);
			u_checker.expect_status(entry.status);
			send_order({entry.kind, entry.plate});
		end
		// One extra test for the reset state
		wait (test_count == stim_table.size() + 1);
		repeat (4) @(negedge clock);
		$display("%0d tests, %0d check errors, %0d assertion failures",
			test_count, error_count, assert_count);
		if (error_count == 0 && assert_count == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

/* testbench/parking_asserts.sv */
//--------------------
// Bound into the queue and the elevator. Unused inputs are tied off at each bind
//--------------------
`timescale 1ns/1ps

module parking_asserts #(
	parameter int NUM_FLOORS = 7
) (
	input logic                           clock,
	input logic                           reset,
	input logic                           req,
	input logic                           ack,
	input logic                           done,
	input logic [parking_pkg::FLOOR_W-1:0] floor
);
	int failures = 0;

	ack_needs_req: assert property (@(posedge clock) disable iff (reset)
		$rose(ack) |-> $past(req))
	else begin
		$error("ack rose while req was low");
		failures++;
	end

	done_single: assert property (@(posedge clock) disable iff (reset)
		done |=> !done)
	else begin
		$error("done_valid lasted two cycles");
		failures++;
	end

	// At most one floor per cycle and never above the top floor
	floor_step: assert property (@(posedge clock) disable iff (reset)
		(floor <= NUM_FLOORS) &&
		({1'b0, floor} + 4'd1 >= {1'b0, $past(floor)}) &&
		({1'b0, $past(floor)} + 4'd1 >= {1'b0, floor}))
	else begin
		$error("current_floor jumped or left the tower");
		failures++;
	end

endmodule

bind order_queue parking_asserts u_queue_asserts (
	.clock, .reset, .req(order_req), .ack(order_ack), .done(1'b0), .floor('0)
);

bind elevator_controller parking_asserts #(.NUM_FLOORS(NUM_FLOORS)) u_elevator_asserts (
	.clock, .reset, .req(1'b0), .ack(1'b0), .done(done_valid), .floor(current_floor)
);

/* testbench/parking_checker.sv */
//--------------------
// Reference model of slots and free counts. Results are sampled while done_valid is high
//--------------------
`timescale 1ns/1ps

module parking_checker #(
	parameter int NUM_FLOORS = 7
) (
	input  logic                           clock,
	input  logic                           reset,
	input  parking_pkg::order_t            order,
	input  logic                           order_ack,
	input  logic                           done_valid,
	input  parking_pkg::result_t           result,
	input  logic [3:0]                     free_sedan,
	input  logic [3:0]                     free_suv,
	input  logic [parking_pkg::FLOOR_W-1:0] current_floor,
	output int                             error_count,
	output int                             test_count
);
	import parking_pkg::*;

	logic [PLATE_W-1:0] model [1:NUM_FLOORS][0:1];
	order_t accepted_q [$];
	status_t status_q [$];
	logic ack_d;
	logic check_reset_state;

	initial begin
		error_count = 0;
		test_count = 0;
		ack_d = 1'b0;
		check_reset_state = 1'b0;
		foreach (model[f, s])
			model[f][s] = '0;
	end

	task automatic expect_status(input status_t status);
		status_q.push_back(status);
	endtask

	task automatic compare(input string name, input logic [31:0] got,
			input logic [31:0] want, inout int errs);
		if (got !== want) begin
			$display("FAIL %s: expected 0x%0h got 0x%0h", name, want, got);
			errs++;
		end
	endtask

	// Reserved left slots of floors 1 and 2 are not counted
	function automatic int count_free(input logic sedan);
		int n;
		n = 0;
		for (int f = 1; f <= NUM_FLOORS; f++)
			for (int s = 0; s < 2; s++)
				if (!(f <= 2 && s == 0) && model[f][s] == '0 && ((f % 2 == 0) == sedan))
					n++;
		return n;
	endfunction

	task automatic finish_test(input string what, input logic [PLATE_W-1:0] plate,
			input int errs);
		$display("Test %0d %s plate 0x%h: %0d errors", test_count, what, plate, errs);
		error_count += errs;
		test_count++;
	endtask

	task automatic check_result();
		order_t o;
		status_t want;
		slot_t slot;
		logic found;
		logic park;
		int errs;
		errs = 0;
		found = 1'b0;
		slot = '0;
		if (accepted_q.size() == 0 || status_q.size() == 0) begin
			$display("Result for plate 0x%h arrived with no accepted order", result.plate);
			error_count++;
			return;
		end
		o = accepted_q.pop_front();
		want = status_q.pop_front();
		park = (o.kind == PARK);
		// Lowest floor first, left before right
		for (int f = 1; f <= NUM_FLOORS; f++) begin
			for (int s = 0; s < 2; s++) begin
				if (!found && !park && model[f][s] == o.plate)
					found = 1'b1;
				if (!found && park && model[f][s] == '0 && ((f % 2 == 0) == !o.plate[0]) &&
						(o.plate[15:12] == 4'h9 || !(f <= 2 && s == 0)))
					found = 1'b1;
				if (found && slot == '0) begin
					slot.floor = FLOOR_W'(f);
					slot.side = side_t'(s);
				end
			end
		end
		if (found)
			model[slot.floor][slot.side] = park ? o.plate : '0;
		if (found != (want == OK)) begin
			$display("Reference model and stimulus table disagree on plate 0x%h", o.plate);
			errs++;
		end
		compare("result.kind", result.kind, o.kind, errs);
		compare("result.plate", result.plate, o.plate, errs);
		compare("result.status", result.status, want, errs);
		if (want == OK)
			compare("result.slot", result.slot, slot, errs);
		// Handicapped cars park free, hybrids pay odd amounts too
		if (!park && want == OK && o.plate[15:12] != 4'h9) begin
			if (result.fee == 0 || (o.plate[15:12] != 4'h8 && result.fee[0])) begin
				$display("FAIL result.fee: 0x%h out of class for plate 0x%h", result.fee, o.plate);
				errs++;
			end
		end else begin
			compare("result.fee", result.fee, 0, errs);
		end
		compare("free_sedan", free_sedan, count_free(1'b1), errs);
		compare("free_suv", free_suv, count_free(1'b0), errs);
		finish_test(park ? "park" : "retrieve", o.plate, errs);
	endtask

	task automatic check_reset();
		int errs;
		errs = 0;
		compare("order_ack", order_ack, 0, errs);
		compare("done_valid", done_valid, 0, errs);
		compare("current_floor", current_floor, 0, errs);
		compare("free_sedan", free_sedan, count_free(1'b1), errs);
		compare("free_suv", free_suv, count_free(1'b0), errs);
		finish_test("reset", '0, errs);
	endtask

	always @(posedge clock) begin
		if (reset) begin
			ack_d = 1'b0;
			check_reset_state = 1'b1;
		end else begin
			if (check_reset_state)
				check_reset();
			check_reset_state = 1'b0;
			// Order is still held when ack is first seen high
			if (order_ack && !ack_d)
				accepted_q.push_back(order);
			ack_d = order_ack;
			if (done_valid)
				check_result();
		end
	end

endmodule

/* verilog/parking_tower_top.sv */
//--------------------
// Floors 1..NUM_FLOORS hold two slots each; NUM_FLOORS must fit in FLOOR_W bits
//--------------------
`timescale 1ns/1ps

module parking_tower_top #(
	parameter int NUM_FLOORS = 7,
	parameter int QUEUE_DEPTH = 8
) (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           order_req,
	input  parking_pkg::order_t            order,
	output logic                           order_ack,
	output logic                           done_valid,
	output parking_pkg::result_t           result,
	output logic [3:0]                     free_sedan,
	output logic [3:0]                     free_suv,
	output logic [parking_pkg::FLOOR_W-1:0] current_floor
);
	import parking_pkg::*;

	order_t head;
	logic head_valid;
	logic pop;
	slot_t park_slot;
	slot_t find_slot;
	logic park_ok;
	logic find_ok;
	logic [NUM_FLOORS:1][1:0][PLATE_W-1:0] slots;
	logic [NUM_FLOORS:1][1:0][FEE_W-1:0] fee_array;

	order_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
		.clock, .reset, .order_req, .order, .order_ack,
		.head, .head_valid, .pop
	);

	// Allocator always looks at the queue head, which is what IDLE pops
	slot_allocator #(.NUM_FLOORS(NUM_FLOORS)) u_allocator (
		.slots, .plate(head.plate), .park_slot, .park_ok,
		.find_slot, .find_ok, .free_sedan, .free_suv
	);

	elevator_controller #(.NUM_FLOORS(NUM_FLOORS)) u_elevator (
		.clock, .reset, .head, .head_valid, .pop,
		.park_slot, .find_slot, .park_ok, .find_ok,
		.fee_array, .slots, .current_floor, .done_valid, .result
	);

	// One meter per slot
	for (genvar f = 1; f <= NUM_FLOORS; f++) begin : g_floor
		for (genvar s = 0; s < 2; s++) begin : g_side
			parking_fee_meter u_meter (
				.clock, .reset, .plate(slots[f][s]), .fee(fee_array[f][s])
			);
		end
	end

endmodule

/* verilog/elevator_controller.sv */
//--------------------
// One order at a time, one floor per cycle. FULL and NOT_FOUND report without travel
// The result bus is only meaningful while done_valid is high
//--------------------
`timescale 1ns/1ps

module elevator_controller #(
	parameter int NUM_FLOORS = 7
) (
	input  logic                                                clock,
	input  logic                                                reset,
	input  parking_pkg::order_t                                 head,
	input  logic                                                head_valid,
	output logic                                                pop,
	input  parking_pkg::slot_t                                  park_slot,
	input  parking_pkg::slot_t                                  find_slot,
	input  logic                                                park_ok,
	input  logic                                                find_ok,
	input  logic [NUM_FLOORS:1][1:0][parking_pkg::FEE_W-1:0]   fee_array,
	output logic [NUM_FLOORS:1][1:0][parking_pkg::PLATE_W-1:0] slots,
	output logic [parking_pkg::FLOOR_W-1:0]                     current_floor,
	output logic                                                done_valid,
	output parking_pkg::result_t                                result
);
	import parking_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		TO_SLOT,
		LOAD,
		RETURN,
		REPORT
	} state_t;

	state_t state;
	logic retrieve_load;

	// IDLE is only ever entered at floor 0
	assign pop = (state == IDLE) && head_valid;
	assign done_valid = (state == REPORT);
	assign retrieve_load = (state == LOAD) && (result.kind == RETRIEVE);

	// FSM, car position and slot table
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
			current_floor <= '0;
			slots <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (pop) begin
						if (head.kind == PARK)
							state <= park_ok ? TO_SLOT : REPORT;
						else
							state <= find_ok ? TO_SLOT : REPORT;
					end
				end

				// Target floor is at least 1, so at least one step up
				TO_SLOT: begin
					current_floor <= current_floor + 1'b1;
					if (current_floor + 1'b1 == result.slot.floor)
						state <= LOAD;
				end

				// One cycle to move the car between platform and slot
				LOAD: begin
					if (result.kind == PARK) begin
						slots[result.slot.floor][result.slot.side] <= result.plate;
						state <= REPORT;
					end else begin
						slots[result.slot.floor][result.slot.side] <= '0;
						state <= RETURN;
					end
				end

				RETURN: begin
					current_floor <= current_floor - 1'b1;
					if (current_floor == FLOOR_W'(1))
						state <= (result.kind == RETRIEVE) ? REPORT : IDLE;
				end

				// A parked car still leaves the elevator up at the slot
				REPORT: begin
					if (result.kind == PARK && result.status == OK)
						state <= RETURN;
					else
						state <= IDLE;
				end

				default: state <= IDLE;
			endcase
		end
	end

	// Result fields are latched at pop; the fee comes in while unloading
	always_ff @(posedge clock) begin
		if (pop) begin
			result.kind <= head.kind;
			result.plate <= head.plate;
			result.fee <= '0;
			if (head.kind == PARK) begin
				result.slot <= park_ok ? park_slot : slot_t'(0);
				result.status <= park_ok ? OK : FULL;
			end else begin
				result.slot <= find_ok ? find_slot : slot_t'(0);
				result.status <= find_ok ? OK : NOT_FOUND;
			end
		end else if (retrieve_load) begin
			result.fee <= fee_array[result.slot.floor][result.slot.side];
		end
	end

endmodule

/* verilog/slot_allocator.sv */
//--------------------
// Purely combinational. SUVs on odd floors, sedans on even floors
// Left slots of floors 1 and 2 are reserved for handicapped cars
//--------------------
`timescale 1ns/1ps

module slot_allocator #(
	parameter int NUM_FLOORS = 7
) (
	input  logic [NUM_FLOORS:1][1:0][parking_pkg::PLATE_W-1:0] slots,
	input  logic [parking_pkg::PLATE_W-1:0]                    plate,
	output parking_pkg::slot_t                                  park_slot,
	output logic                                                park_ok,
	output parking_pkg::slot_t                                  find_slot,
	output logic                                                find_ok,
	output logic [3:0]                                          free_sedan,
	output logic [3:0]                                          free_suv
);
	import parking_pkg::*;

	function automatic logic is_reserved(input int f, input int s);
		return (f <= 2) && (side_t'(s) == LEFT);
	endfunction

	// Even floors hold sedans
	function automatic logic class_fits(input int f, input logic sedan);
		return ((f % 2) == 0) == sedan;
	endfunction

	// Lowest eligible floor wins, left before right
	always_comb begin : park_search
		logic sedan;
		logic handicapped;
		sedan = is_sedan(plate);
		handicapped = is_handicapped(plate);
		park_ok = 1'b0;
		park_slot = '0;
		for (int f = 1; f <= NUM_FLOORS; f++) begin
			for (int s = 0; s < 2; s++) begin
				if (!park_ok && slots[f][s] == '0 && class_fits(f, sedan) &&
						(handicapped || !is_reserved(f, s))) begin
					park_ok = 1'b1;
					park_slot.floor = FLOOR_W'(f);
					park_slot.side = side_t'(s);
				end
			end
		end
	end

	// Plate lookup; a zero plate never matches
	always_comb begin : plate_search
		find_ok = 1'b0;
		find_slot = '0;
		for (int f = 1; f <= NUM_FLOORS; f++) begin
			for (int s = 0; s < 2; s++) begin
				if (!find_ok && plate != '0 && slots[f][s] == plate) begin
					find_ok = 1'b1;
					find_slot.floor = FLOOR_W'(f);
					find_slot.side = side_t'(s);
				end
			end
		end
	end

	// Reserved slots stay out of both counts
	always_comb begin : free_count
		free_sedan = '0;
		free_suv = '0;
		for (int f = 1; f <= NUM_FLOORS; f++) begin
			for (int s = 0; s < 2; s++) begin
				if (!is_reserved(f, s) && slots[f][s] == '0) begin
					if ((f % 2) == 0)
						free_sedan = free_sedan + 4'd1;
					else
						free_suv = free_suv + 4'd1;
				end
			end
		end
	end

endmodule

/* verilog/order_queue.sv */
//--------------------
// Four-phase req/ack intake; ack is withheld while the FIFO is full
// pop must only be raised while head_valid is high
//--------------------
`timescale 1ns/1ps

module order_queue #(
	parameter int QUEUE_DEPTH = 8
) (
	input  logic                clock,
	input  logic                reset,
	input  logic                order_req,
	input  parking_pkg::order_t order,
	output logic                order_ack,
	output parking_pkg::order_t head,
	output logic                head_valid,
	input  logic                pop
);
	import parking_pkg::*;

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	order_t mem [QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic full;
	logic push;

	assign full = (count == CNT_W'(QUEUE_DEPTH));

	// Ack high means this req was already taken
	assign push = order_req && !order_ack && !full;

	assign head = mem[rd_ptr];
	assign head_valid = (count != '0);

	// Handshake, pointers and fill count
	always_ff @(posedge clock) begin
		if (reset) begin
			order_ack <= 1'b0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				order_ack <= 1'b1;
			else if (!order_req)
				order_ack <= 1'b0;

			if (push) begin
				if (wr_ptr == PTR_W'(QUEUE_DEPTH - 1))
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end

			if (pop) begin
				if (rd_ptr == PTR_W'(QUEUE_DEPTH - 1))
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end

			// Simultaneous push and pop leaves the count unchanged
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Order storage
	always_ff @(posedge clock) begin
		if (push)
			mem[wr_ptr] <= order;
	end

endmodule

/* verilog/parking_fee_meter.sv */
//--------------------
// Clears one cycle after the plate changes, then counts while occupied
//--------------------
`timescale 1ns/1ps

module parking_fee_meter (
	input  logic                          clock,
	input  logic                          reset,
	input  logic [parking_pkg::PLATE_W-1:0] plate,
	output logic [parking_pkg::FEE_W-1:0]   fee
);
	import parking_pkg::*;

	logic [PLATE_W-1:0] prev_plate;
	logic [FEE_W:0] fee_sum;

	// One extra bit to catch the overflow
	assign fee_sum = {1'b0, fee} + (FEE_W + 1)'(fee_rate(plate));

	always_ff @(posedge clock) begin
		if (reset) begin
			prev_plate <= '0;
			fee <= '0;
		end else begin
			prev_plate <= plate;
			if (plate != prev_plate)
				fee <= '0;
			else if (plate != '0) begin
				// Saturate at all ones
				if (fee_sum[FEE_W])
					fee <= '1;
				else
					fee <= fee_sum[FEE_W-1:0];
			end
		end
	end

endmodule

/* verilog/parking_pkg.sv */
//--------------------
// A plate of zero is an empty slot. Floor 0 is the ground, where cars enter and leave
// Fees saturate at 255
//--------------------
package parking_pkg;

	localparam int PLATE_W = 16;
	localparam int FLOOR_W = 3;
	localparam int FEE_W = 8;

	// Top nibble of a plate gives its class
	localparam logic [3:0] CLASS_NIBBLE_HANDICAPPED = 4'd9;
	localparam logic [3:0] CLASS_NIBBLE_HYBRID = 4'd8;

	typedef enum logic {LEFT, RIGHT} side_t;

	typedef struct packed {
		logic [FLOOR_W-1:0] floor;
		side_t side;
	} slot_t;

	typedef enum logic {PARK, RETRIEVE} order_kind_t;

	typedef struct packed {
		order_kind_t kind;
		logic [PLATE_W-1:0] plate;
	} order_t;

	typedef enum logic [1:0] {OK, FULL, NOT_FOUND} status_t;

	typedef struct packed {
		order_kind_t kind;
		logic [PLATE_W-1:0] plate;
		slot_t slot;
		logic [FEE_W-1:0] fee;
		status_t status;
	} result_t;

	// Even plates are sedans, odd plates SUVs
	function automatic logic is_sedan(input logic [PLATE_W-1:0] plate);
		return !plate[0];
	endfunction

	function automatic logic is_handicapped(input logic [PLATE_W-1:0] plate);
		return plate[PLATE_W-1 -: 4] == CLASS_NIBBLE_HANDICAPPED;
	endfunction

	// Fee added per cycle of parking
	function automatic logic [1:0] fee_rate(input logic [PLATE_W-1:0] plate);
		if (is_handicapped(plate))
			return 2'd0;
		if (plate[PLATE_W-1 -: 4] == CLASS_NIBBLE_HYBRID)
			return 2'd1;
		return 2'd2;
	endfunction

endpackage
